//--- dv/jtag_host_tasks.svh
/*
 * Host-side JTAG bit-banging and typed compare tasks, included inside the testbench module.
 * TCK runs at 8 clk per half period; TMS and TDI change with falling TCK.
 */
`ifndef JTAG_HOST_TASKS_SVH
`define JTAG_HOST_TASKS_SVH

// Wait for clock edges, then step past the edge before driving
task automatic wait_clks(input int count);
    repeat (count) @(posedge clk);
    #2;
endtask

// One TCK period: low phase with new TMS/TDI, TDO sampled just before rising TCK
task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo_bit);
    jtag.tck = 1'b0;
    jtag.tms = tms;
    jtag.tdi = tdi;
    wait_clks(TCK_HALF_CLKS);
    tdo_bit = tdo;
    jtag.tck = 1'b1;
    wait_clks(TCK_HALF_CLKS);
endtask

// Five TMS ones reach Test-Logic-Reset, then park in Run-Test/Idle
task automatic tap_reset();
    logic unused_bit;
    for (int i = 0; i < 5; i++)
        tck_cycle(1'b1, 1'b0, unused_bit);
    tck_cycle(1'b0, 1'b0, unused_bit);
    tck_cycle(1'b0, 1'b0, unused_bit);
endtask

// Load the instruction register, LSB first, returns the captured IR bits
task automatic scan_ir(input jtag_inst_t inst, output logic [JTAG_IR_WIDTH-1:0] captured);
    logic [JTAG_IR_WIDTH-1:0] code;
    logic bit_out;
    code = inst;
    captured = '0;
    // Idle to Select-DR, Select-IR, Capture-IR, Shift-IR
    tck_cycle(1'b1, 1'b0, bit_out);
    tck_cycle(1'b1, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
    // Last bit leaves Shift-IR
    for (int i = 0; i < JTAG_IR_WIDTH; i++)
    begin
        tck_cycle(i == JTAG_IR_WIDTH - 1, code[i], bit_out);
        captured[i] = bit_out;
    end
    // Update-IR, Idle, then one idle period for the logic to settle
    tck_cycle(1'b1, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
endtask

// Shift width bits through the selected data register, LSB first
task automatic scan_dr(input int width, input scalar_t data_in, output scalar_t data_out);
    logic bit_out;
    data_out = '0;
    // Idle to Select-DR, Capture-DR, Shift-DR
    tck_cycle(1'b1, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
    for (int i = 0; i < width; i++)
    begin
        tck_cycle(i == width - 1, data_in[i], bit_out);
        data_out[i] = bit_out;
    end
    // Update-DR, Idle, and a full idle TCK period covering all latencies
    tck_cycle(1'b1, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
    tck_cycle(1'b0, 1'b0, bit_out);
endtask

task automatic check_scalar(input scalar_t actual, input scalar_t expected, input string what);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("Fail at %0t: %s: got %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic check_status(input debug_status_t actual, input debug_status_t expected,
                            input string what);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("Fail at %0t: %s: ovf/core/thread/halt %b/%0d/%0d/%b, expected %b/%0d/%0d/%b",
                 $time, what, actual.overflow, actual.control.core, actual.control.thread,
                 actual.control.halt, expected.overflow, expected.control.core,
                 expected.control.thread, expected.control.halt);
    end
endtask

task automatic check_bit(input logic actual, input logic expected, input string what);
    check_count++;
    if (actual !== expected)
    begin
        error_count++;
        $display("Fail at %0t: %s: got %b, expected %b", $time, what, actual, expected);
    end
endtask

`endif

//--- dv/jtag_debug_tb.sv
/*
 * Directed testbench driving the debug subsystem through its JTAG pins only.
 * Each scan ends with an idle TCK period, long enough for FIFO and target latency.
 */
`timescale 1ns/1ps

module jtag_debug_tb;

    import debug_pkg::*;

    // 8 clk per TCK half period keeps TCK below clk/8
    localparam int TCK_HALF_CLKS = 8;
    // About 1170 TCK periods of 16 clk in all, so near 19k clk with wide margin
    localparam int TIMEOUT_CLKS = 200_000;

    logic clk;
    logic reset;
    jtag_in_t jtag;
    logic tdo;
    logic dbg_halt;

    int error_count;
    int check_count;
    int cycle_count;
    logic [31:0] lfsr_state;

    `include "jtag_host_tasks.svh"

    jtag_debug_top i_dut
        (.clk(clk),
        .reset(reset),
        .jtag(jtag),
        .tdo(tdo),
        .dbg_halt(dbg_halt));

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one bit per step
    function automatic logic lfsr_step();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic scalar_t random_bits(input int count);
        scalar_t value;
        value = '0;
        for (int i = 0; i < count; i++)
            value = {value[30:0], lfsr_step()};
        return value;
    endfunction

    // Debug instruction layout: op 31:28, register 27:26, immediate 15:0
    function automatic scalar_t make_inst(input debug_op_t op, input reg_idx_t rsel,
                                          input logic [15:0] imm);
        return {op, rsel, 10'd0, imm};
    endfunction

    function automatic scalar_t sign_extend(input logic [15:0] value);
        return {{16{value[15]}}, value};
    endfunction

    // CONTROL scan: writes ctrl, returns status captured before the write
    task automatic write_control(input debug_control_t ctrl, output debug_status_t status);
        logic [JTAG_IR_WIDTH-1:0] ir_bits;
        scalar_t got;
        scan_ir(INST_CONTROL, ir_bits);
        scan_dr(STATUS_WIDTH, SCALAR_WIDTH'({1'b0, ctrl}), got);
        status = debug_status_t'(got[STATUS_WIDTH-1:0]);
    endtask

    task automatic write_host_data(input scalar_t value);
        logic [JTAG_IR_WIDTH-1:0] ir_bits;
        scalar_t got;
        scan_ir(INST_WRITE_DATA, ir_bits);
        scan_dr(SCALAR_WIDTH, value, got);
    endtask

    task automatic inject_inst(input scalar_t inst);
        logic [JTAG_IR_WIDTH-1:0] ir_bits;
        scalar_t got;
        scan_ir(INST_INJECT_INST, ir_bits);
        scan_dr(SCALAR_WIDTH, inst, got);
    endtask

    task automatic read_data(output scalar_t value);
        logic [JTAG_IR_WIDTH-1:0] ir_bits;
        scan_ir(INST_READ_DATA, ir_bits);
        scan_dr(SCALAR_WIDTH, '0, value);
    endtask

    // IDCODE is the default DR after reset, BYPASS delays by one bit
    task automatic test_idcode_bypass();
        logic [JTAG_IR_WIDTH-1:0] ir_bits;
        scalar_t got;
        scalar_t pattern;
        pattern = 32'h0000_b5c3;
        tap_reset();
        scan_dr(SCALAR_WIDTH, '0, got);
        check_scalar(got, JTAG_IDCODE, "IDCODE after TAP reset");
        scan_ir(INST_BYPASS, ir_bits);
        // 1149.1 IR capture ends in 01
        check_scalar(SCALAR_WIDTH'(ir_bits), 32'h1, "IR capture value");
        scan_dr(16, pattern, got);
        check_scalar(got, {16'd0, pattern[14:0], 1'b0}, "BYPASS one-bit delay");
    endtask

    task automatic test_control();
        debug_control_t ctrl;
        debug_status_t status;
        ctrl = '{core: TARGET_CORE_ID, thread: 2'd2, halt: 1'b1};
        write_control(ctrl, status);
        check_status(status, '0, "CONTROL capture after reset");
        check_bit(dbg_halt, 1'b1, "dbg_halt after CONTROL write");
        write_control(ctrl, status);
        check_status(status, '{overflow: 1'b0, control: ctrl}, "CONTROL read back");
    endtask

    // LOAD_HOST must see the host word current at injection
    task automatic test_host_data();
        scalar_t word;
        scalar_t got;
        word = random_bits(32);
        write_host_data(word);
        inject_inst(make_inst(OP_LOAD_HOST, 2'd1, 16'd0));
        inject_inst(make_inst(OP_STORE_HOST, 2'd1, 16'd0));
        read_data(got);
        check_scalar(got, word, "host word through r1");
    endtask

    task automatic test_thread_regs();
        scalar_t rnd;
        scalar_t got;
        scalar_t expected;
        logic [15:0] imm_a;
        logic [15:0] imm_b;
        debug_control_t ctrl;
        debug_status_t status;
        rnd = random_bits(16);
        imm_a = rnd[15:0];
        rnd = random_bits(16);
        imm_b = rnd[15:0];
        expected = {16'd0, imm_a} + sign_extend(imm_b);
        inject_inst(make_inst(OP_LOADI, 2'd0, imm_a));
        inject_inst(make_inst(OP_ADDI, 2'd0, imm_b));
        inject_inst(make_inst(OP_STORE_HOST, 2'd0, 16'd0));
        read_data(got);
        check_scalar(got, expected, "LOADI plus ADDI in r0");
        // Thread 3 has its own r0
        ctrl = '{core: TARGET_CORE_ID, thread: 2'd3, halt: 1'b1};
        write_control(ctrl, status);
        inject_inst(make_inst(OP_STORE_HOST, 2'd0, 16'd0));
        read_data(got);
        check_scalar(got, '0, "r0 of thread 3 untouched");
        // Back to thread 2, value still there
        ctrl.thread = 2'd2;
        write_control(ctrl, status);
        inject_inst(make_inst(OP_STORE_HOST, 2'd0, 16'd0));
        read_data(got);
        check_scalar(got, expected, "r0 of thread 2 kept");
    endtask

    // Five commands while running, only four fit in the FIFO
    task automatic test_overflow();
        scalar_t rnd;
        scalar_t got;
        scalar_t expected;
        logic [15:0] imm[5];
        debug_control_t ctrl;
        debug_status_t status;
        for (int i = 0; i < 5; i++)
        begin
            rnd = random_bits(16);
            imm[i] = rnd[15:0];
        end
        ctrl = '{core: TARGET_CORE_ID, thread: 2'd2, halt: 1'b0};
        write_control(ctrl, status);
        check_bit(dbg_halt, 1'b0, "dbg_halt after halt clear");
        inject_inst(make_inst(OP_LOADI, 2'd2, imm[0]));
        for (int i = 1; i < 4; i++)
            inject_inst(make_inst(OP_ADDI, 2'd2, imm[i]));
        // Dropped, would overwrite r2
        inject_inst(make_inst(OP_LOADI, 2'd2, imm[4]));
        write_control(ctrl, status);
        check_status(status, '{overflow: 1'b1, control: ctrl}, "overflow after fifth command");
        // Halting drains the four held commands
        ctrl.halt = 1'b1;
        write_control(ctrl, status);
        check_bit(dbg_halt, 1'b1, "dbg_halt after halt set");
        inject_inst(make_inst(OP_STORE_HOST, 2'd2, 16'd0));
        read_data(got);
        expected = {16'd0, imm[0]} + sign_extend(imm[1]) + sign_extend(imm[2])
                   + sign_extend(imm[3]);
        check_scalar(got, expected, "only first four commands ran");
    endtask

    // Run limit
    initial
    begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CLKS)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run stopped after %0d clock cycles without finishing", cycle_count);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        error_count = 0;
        check_count = 0;
        lfsr_state = 32'hff60;
        reset = 1'b1;
        jtag = '{tck: 1'b0, tms: 1'b1, tdi: 1'b0};
        wait_clks(2);
        reset = 1'b0;
        wait_clks(2);

        test_idcode_bypass();
        test_control();
        test_host_data();
        test_thread_regs();
        test_overflow();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- hdl/debug_cmd_fifo.sv
/*
 * Circular buffer of debug commands, push and pop allowed in one cycle.
 * Depth must be a power of two so the pointers wrap on their own.
 */
`timescale 1ns/1ps

module debug_cmd_fifo
    (input logic                     clk,
    input logic                      reset,
    input logic                      in_valid,
    input debug_pkg::debug_cmd_t     in_cmd,
    output logic                     in_ready,
    output logic                     out_valid,
    output debug_pkg::debug_cmd_t    out_cmd,
    input logic                      out_ready);

    import debug_pkg::*;

    debug_cmd_t entries[CMD_FIFO_DEPTH];
    logic [CMD_FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [CMD_FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [CMD_FIFO_COUNT_WIDTH-1:0] count;
    logic push;
    logic pop;

    // Ready only depends on occupancy, not on a pop in the same cycle
    assign in_ready = count < CMD_FIFO_COUNT_WIDTH'(CMD_FIFO_DEPTH);
    assign out_valid = count != '0;
    assign out_cmd = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    // Storage
    always_ff @(posedge clk)
    begin
        if (push)
            entries[wr_ptr] <= in_cmd;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;

            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            // Simultaneous push and pop leave the count alone
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hdl/debug_controller.sv
/*
 * tdi is used unsynchronized and must hold steady for half a TCK period after rising TCK.
 * A command offered while the FIFO is full is dropped and sets the sticky overflow flag.
 */
`timescale 1ns/1ps

module debug_controller
    (input logic                         clk,
    input logic                          reset,
    input logic                          tdi,
    input debug_pkg::jtag_inst_t         instruction,
    input logic                          capture_dr,
    input logic                          shift_dr,
    input logic                          update_dr,
    output logic                         dr_out,
    output debug_pkg::debug_control_t    control,
    output logic                         cmd_valid,
    output debug_pkg::debug_cmd_t        cmd,
    input logic                          cmd_ready,
    input debug_pkg::scalar_t            data_to_host);

    import debug_pkg::*;

    scalar_t data_shift;
    scalar_t host_data;
    logic overflow;
    logic inject_update;
    debug_status_t status;

    // Status seen by a CONTROL read
    assign status = '{overflow: overflow, control: control};

    // LSB leaves first
    assign dr_out = data_shift[0];

    assign inject_update = update_dr && instruction == INST_INJECT_INST;

    // Capture and shift of the selected data register
    always_ff @(posedge clk)
    begin
        if (capture_dr)
        begin
            case (instruction)
                INST_IDCODE: data_shift <= JTAG_IDCODE;
                INST_CONTROL: data_shift <= SCALAR_WIDTH'(status);
                INST_READ_DATA: data_shift <= data_to_host;
                default: data_shift <= '0;
            endcase
        end
        else if (shift_dr)
        begin
            case (instruction)
                // Full 32-bit registers
                INST_IDCODE, INST_INJECT_INST, INST_READ_DATA, INST_WRITE_DATA:
                    data_shift <= {tdi, data_shift[SCALAR_WIDTH-1:1]};

                // Status is only 6 bits long
                INST_CONTROL:
                    data_shift <= SCALAR_WIDTH'({tdi, data_shift[STATUS_WIDTH-1:1]});

                // BYPASS and unknown codes, single bit
                default:
                    data_shift <= SCALAR_WIDTH'(tdi);
            endcase
        end
    end

    // Host data word, written by WRITE_DATA
    always_ff @(posedge clk)
    begin
        if (update_dr && instruction == INST_WRITE_DATA)
            host_data <= data_shift;
    end

    // Command payload pairs the instruction with the current host word
    always_ff @(posedge clk)
    begin
        if (inject_update)
        begin
            cmd.instruction <= data_shift;
            cmd.host_data <= host_data;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            control <= '0;
            cmd_valid <= 1'b0;
            overflow <= 1'b0;
        end
        else
        begin
            // One-cycle offer, no retry
            cmd_valid <= inject_update;

            // Overflow bit of a CONTROL write is ignored
            if (update_dr && instruction == INST_CONTROL)
                control <= debug_control_t'(data_shift[CONTROL_WIDTH-1:0]);

            if (cmd_valid && !cmd_ready)
                overflow <= 1'b1;
        end
    end

endmodule

//--- hdl/debug_pkg.sv
/*
 * Types and constants shared by the JTAG debug subsystem.
 * IR codes outside the named set behave as BYPASS. The overflow flag is sticky until reset.
 */
package debug_pkg;

    // Basic widths
    localparam int SCALAR_WIDTH = 32;
    localparam int JTAG_IR_WIDTH = 4;
    localparam int THREADS_PER_CORE = 4;
    localparam int REGS_PER_THREAD = 4;
    localparam int THREAD_IDX_WIDTH = $clog2(THREADS_PER_CORE);
    localparam int REG_IDX_WIDTH = $clog2(REGS_PER_THREAD);
    localparam int TARGET_NUM_REGS = THREADS_PER_CORE * REGS_PER_THREAD;

    typedef logic [SCALAR_WIDTH-1:0] scalar_t;
    typedef logic [1:0] core_id_t;
    typedef logic [THREAD_IDX_WIDTH-1:0] thread_idx_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [THREAD_IDX_WIDTH+REG_IDX_WIDTH-1:0] target_reg_addr_t;

    // Arbitrary part number, bit 0 set as 1149.1 requires
    localparam scalar_t JTAG_IDCODE = 32'h4a7d_0c51;

    // Core number answered by the debug target in this build
    localparam core_id_t TARGET_CORE_ID = 2'd1;

    // Pins driven by the host, tck on top
    typedef struct packed {
        logic tck;
        logic tms;
        logic tdi;
    } jtag_in_t;

    typedef enum logic [JTAG_IR_WIDTH-1:0] {
        INST_IDCODE = 4'd0,
        INST_CONTROL = 4'd3,
        INST_INJECT_INST = 4'd4,
        INST_READ_DATA = 4'd5,
        INST_WRITE_DATA = 4'd6,
        INST_BYPASS = 4'd15
    } jtag_inst_t;

    // Halt sits in bit 0, core in the top bits
    typedef struct packed {
        core_id_t core;
        thread_idx_t thread;
        logic halt;
    } debug_control_t;

    // CONTROL capture value, overflow shifted out last
    typedef struct packed {
        logic overflow;
        debug_control_t control;
    } debug_status_t;

    localparam int CONTROL_WIDTH = $bits(debug_control_t);
    localparam int STATUS_WIDTH = $bits(debug_status_t);

    // Injected instruction plus the host word current at injection
    typedef struct packed {
        scalar_t instruction;
        scalar_t host_data;
    } debug_cmd_t;

    // Debug instruction fields
    localparam int OP_WIDTH = 4;
    localparam int OP_LSB = 28;
    localparam int REG_LSB = 26;
    localparam int IMM_WIDTH = 16;

    typedef enum logic [OP_WIDTH-1:0] {
        OP_NOP = 4'd0,
        OP_LOAD_HOST = 4'd1,
        OP_STORE_HOST = 4'd2,
        OP_ADDI = 4'd3,
        OP_LOADI = 4'd4
    } debug_op_t;

    // Command FIFO sizing
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int CMD_FIFO_ADDR_WIDTH = $clog2(CMD_FIFO_DEPTH);
    localparam int CMD_FIFO_COUNT_WIDTH = $clog2(CMD_FIFO_DEPTH + 1);

endpackage

//--- hdl/debug_target.sv
/*
 * Stand-in for a core debug port with four threads of four registers.
 * Commands are taken only while halted and addressed; unknown opcodes are consumed silently.
 */
`timescale 1ns/1ps

module debug_target
    (input logic                         clk,
    input logic                          reset,
    input debug_pkg::debug_control_t     control,
    input logic                          cmd_valid,
    input debug_pkg::debug_cmd_t         cmd,
    output logic                         cmd_ready,
    output debug_pkg::scalar_t           data_to_host);

    import debug_pkg::*;

    scalar_t regs[TARGET_NUM_REGS];
    logic accept;
    debug_op_t op;
    target_reg_addr_t reg_addr;
    logic [IMM_WIDTH-1:0] imm;
    scalar_t imm_sext;
    scalar_t imm_zext;

    // Only a halted core with our number drains the FIFO
    assign cmd_ready = control.halt && control.core == TARGET_CORE_ID;
    assign accept = cmd_valid && cmd_ready;

    // Instruction decode
    assign op = debug_op_t'(cmd.instruction[OP_LSB +: OP_WIDTH]);
    // Thread comes from the control register, not from the command
    assign reg_addr = {control.thread, cmd.instruction[REG_LSB +: REG_IDX_WIDTH]};
    assign imm = cmd.instruction[IMM_WIDTH-1:0];
    assign imm_sext = {{(SCALAR_WIDTH - IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    assign imm_zext = SCALAR_WIDTH'(imm);

    // Execute in the accept cycle, result visible next clk
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < TARGET_NUM_REGS; i++)
                regs[i] <= '0;

            data_to_host <= '0;
        end
        else if (accept)
        begin
            case (op)
                OP_LOAD_HOST: regs[reg_addr] <= cmd.host_data;
                OP_STORE_HOST: data_to_host <= regs[reg_addr];
                OP_ADDI: regs[reg_addr] <= regs[reg_addr] + imm_sext;
                OP_LOADI: regs[reg_addr] <= imm_zext;
                // NOP and unused codes
                default: ;
            endcase
        end
    end

endmodule

//--- hdl/jtag_debug_top.sv
/*
 * JTAG debug subsystem: TAP, debug controller, command FIFO and debug target.
 * TCK must be slower than clk/8; TRST and boundary scan are not provided.
 */
`timescale 1ns/1ps

module jtag_debug_top
    (input logic                     clk,
    input logic                      reset,
    input debug_pkg::jtag_in_t       jtag,
    output logic                     tdo,
    output logic                     dbg_halt);

    import debug_pkg::*;

    // TAP to controller
    jtag_inst_t instruction;
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic dr_out;

    // Controller to FIFO
    logic cmd_valid;
    debug_cmd_t cmd;
    logic cmd_ready;

    // FIFO to target
    logic target_valid;
    debug_cmd_t target_cmd;
    logic target_ready;

    // Controller and target
    debug_control_t control;
    scalar_t data_to_host;

    assign dbg_halt = control.halt;

    jtag_tap_controller i_tap
        (.clk(clk),
        .reset(reset),
        .jtag(jtag),
        .dr_out(dr_out),
        .tdo(tdo),
        .instruction(instruction),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .update_dr(update_dr));

    debug_controller i_controller
        (.clk(clk),
        .reset(reset),
        .tdi(jtag.tdi),
        .instruction(instruction),
        .capture_dr(capture_dr),
        .shift_dr(shift_dr),
        .update_dr(update_dr),
        .dr_out(dr_out),
        .control(control),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .cmd_ready(cmd_ready),
        .data_to_host(data_to_host));

    debug_cmd_fifo i_fifo
        (.clk(clk),
        .reset(reset),
        .in_valid(cmd_valid),
        .in_cmd(cmd),
        .in_ready(cmd_ready),
        .out_valid(target_valid),
        .out_cmd(target_cmd),
        .out_ready(target_ready));

    debug_target i_target
        (.clk(clk),
        .reset(reset),
        .control(control),
        .cmd_valid(target_valid),
        .cmd(target_cmd),
        .cmd_ready(target_ready),
        .data_to_host(data_to_host));

endmodule

//--- hdl/jtag_tap_controller.sv
/*
 * TCK is oversampled by clk, so TCK must run slower than clk/8.
 * State moves 3 clk after rising TCK; TDO moves 3 clk after falling TCK.
 */
`timescale 1ns/1ps

module jtag_tap_controller
    (input logic                      clk,
    input logic                       reset,
    input debug_pkg::jtag_in_t        jtag,
    input logic                       dr_out,
    output logic                      tdo,
    output debug_pkg::jtag_inst_t     instruction,
    output logic                      capture_dr,
    output logic                      shift_dr,
    output logic                      update_dr);

    import debug_pkg::*;

    typedef enum logic [3:0] {
        TAP_RESET,
        TAP_IDLE,
        TAP_SELECT_DR,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } tap_state_t;

    jtag_in_t jtag_meta;
    jtag_in_t jtag_sync;
    logic tck_last;
    logic tck_rise;
    logic tck_fall;
    tap_state_t state;
    tap_state_t next_state;
    logic [JTAG_IR_WIDTH-1:0] ir_shift;

    // Two-flop synchronizer for all pins, then the TCK edge register
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            jtag_meta <= '0;
            jtag_sync <= '0;
            tck_last <= 1'b0;
        end
        else
        begin
            jtag_meta <= jtag;
            jtag_sync <= jtag_meta;
            tck_last <= jtag_sync.tck;
        end
    end

    assign tck_rise = jtag_sync.tck && !tck_last;
    assign tck_fall = !jtag_sync.tck && tck_last;

    // Standard 1149.1 state graph, TMS chooses the branch
    always_comb
    begin
        case (state)
            TAP_RESET: next_state = jtag_sync.tms ? TAP_RESET : TAP_IDLE;
            TAP_IDLE: next_state = jtag_sync.tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_DR: next_state = jtag_sync.tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
            TAP_CAPTURE_DR: next_state = jtag_sync.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_SHIFT_DR: next_state = jtag_sync.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
            TAP_EXIT1_DR: next_state = jtag_sync.tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
            TAP_PAUSE_DR: next_state = jtag_sync.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
            TAP_EXIT2_DR: next_state = jtag_sync.tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
            TAP_UPDATE_DR: next_state = jtag_sync.tms ? TAP_SELECT_DR : TAP_IDLE;
            TAP_SELECT_IR: next_state = jtag_sync.tms ? TAP_RESET : TAP_CAPTURE_IR;
            TAP_CAPTURE_IR: next_state = jtag_sync.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_SHIFT_IR: next_state = jtag_sync.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
            TAP_EXIT1_IR: next_state = jtag_sync.tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
            TAP_PAUSE_IR: next_state = jtag_sync.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
            TAP_EXIT2_IR: next_state = jtag_sync.tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
            TAP_UPDATE_IR: next_state = jtag_sync.tms ? TAP_SELECT_DR : TAP_IDLE;
            default: next_state = TAP_RESET;
        endcase
    end

    // DR pulses come out with the state change they belong to
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= TAP_RESET;
            capture_dr <= 1'b0;
            shift_dr <= 1'b0;
            update_dr <= 1'b0;
        end
        else
        begin
            capture_dr <= tck_rise && next_state == TAP_CAPTURE_DR;
            // Every rising edge spent in Shift-DR moves one bit
            shift_dr <= tck_rise && state == TAP_SHIFT_DR;
            update_dr <= tck_rise && next_state == TAP_UPDATE_DR;
            if (tck_rise)
                state <= next_state;
        end
    end

    // Instruction register, back to IDCODE on entering Test-Logic-Reset
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            instruction <= INST_IDCODE;
        else if (tck_rise)
        begin
            if (next_state == TAP_RESET)
                instruction <= INST_IDCODE;
            else if (next_state == TAP_UPDATE_IR)
                instruction <= jtag_inst_t'(ir_shift);
        end
    end

    // IR shift path, capture value ends in 01
    always_ff @(posedge clk)
    begin
        if (tck_rise)
        begin
            if (next_state == TAP_CAPTURE_IR)
                ir_shift <= JTAG_IR_WIDTH'(1);
            else if (state == TAP_SHIFT_IR)
                ir_shift <= {jtag_sync.tdi, ir_shift[JTAG_IR_WIDTH-1:1]};
        end
    end

    // TDO follows falling TCK; low outside the shift states
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            tdo <= 1'b0;
        else if (tck_fall)
        begin
            if (state == TAP_SHIFT_DR)
                tdo <= dr_out;
            else if (state == TAP_SHIFT_IR)
                tdo <= ir_shift[0];
            else
                tdo <= 1'b0;
        end
    end

endmodule

//--- jtag_debug_top.f
+incdir+dv
hdl/debug_pkg.sv
hdl/jtag_tap_controller.sv
hdl/debug_controller.sv
hdl/debug_cmd_fifo.sv
hdl/debug_target.sv
hdl/jtag_debug_top.sv
dv/jtag_debug_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the JTAG debug testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f jtag_debug_top.f --top-module jtag_debug_tb \
    --Mdir obj_dir -o jtag_debug_sim

./obj_dir/jtag_debug_sim > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
echo "Simulation passed"
